//--- vlog.f
verilog/dispatch_pkg.sv
verilog/last_thread_find.sv
verilog/elastic_buffer.sv
verilog/dispatch_lane.sv
verilog/stall_counters.sv
verilog/dispatch_top.sv
sim/dispatch_checker.sv
sim/tb_dispatch.sv

//--- sim/tb_dispatch.sv
`timescale 1ns/1ps

module tb_dispatch import dispatch_pkg::*; ();

    localparam int ISSUE_WIDTH   = 2;
    localparam int PERF_CTR_BITS = 16;
    localparam int NUM_ROWS      = 20;
    localparam int CYCLE_LIMIT   = 20 * NUM_ROWS + 200;

    typedef struct packed {
        logic         lane;
        ex_unit_e     ex_type;
        logic [3:0]   tmask;
        logic [1:0]   exp_tid;
        logic [7:0]   ready_pat;   // bit lane*4+unit
        logic [7:0]   hold;        // cycles before readies are released
    } stim_row_t;

    logic                                        clk;
    logic                                        reset;
    logic      [ISSUE_WIDTH-1:0]                 op_valid;
    operands_t [ISSUE_WIDTH-1:0]                 op_data;
    logic      [ISSUE_WIDTH-1:0]                 op_ready;
    logic      [ISSUE_WIDTH-1:0][NT_BITS-1:0]    row_tid;
    logic      [ISSUE_WIDTH-1:0][NUM_UNITS-1:0]  unit_valid;
    dispatch_t [ISSUE_WIDTH-1:0][NUM_UNITS-1:0]  unit_data;
    logic      [ISSUE_WIDTH-1:0][NUM_UNITS-1:0]  unit_ready;
    logic [NUM_UNITS-1:0][PERF_CTR_BITS-1:0]     stall_count;

    int          error_count;
    int          check_count;
    int          pending;
    int          cycle_count = 0;
    logic [31:0] lfsr_state;
    stim_row_t   rows [NUM_ROWS];

    dispatch_top #(
        .ISSUE_WIDTH   (ISSUE_WIDTH),
        .PERF_CTR_BITS (PERF_CTR_BITS)
    ) dut_i (
        .clk         (clk),
        .reset       (reset),
        .op_valid    (op_valid),
        .op_data     (op_data),
        .op_ready    (op_ready),
        .unit_valid  (unit_valid),
        .unit_data   (unit_data),
        .unit_ready  (unit_ready),
        .stall_count (stall_count)
    );

    dispatch_checker #(
        .ISSUE_WIDTH   (ISSUE_WIDTH),
        .PERF_CTR_BITS (PERF_CTR_BITS)
    ) checker_i (
        .clk         (clk),
        .reset       (reset),
        .op_valid    (op_valid),
        .op_data     (op_data),
        .op_ready    (op_ready),
        .exp_tid     (row_tid),
        .unit_valid  (unit_valid),
        .unit_data   (unit_data),
        .unit_ready  (unit_ready),
        .stall_count (stall_count),
        .error_count (error_count),
        .check_count (check_count),
        .pending     (pending)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic load_table();
        rows[0]  = '{1'b0, EX_ALU, 4'b0001, 2'd0, 8'hFF, 8'd0};
        rows[1]  = '{1'b1, EX_LSU, 4'b1111, 2'd3, 8'hFF, 8'd0};
        rows[2]  = '{1'b0, EX_FPU, 4'b0000, 2'd0, 8'hFF, 8'd0};
        rows[3]  = '{1'b1, EX_SFU, 4'b0101, 2'd2, 8'hFF, 8'd0};
        // Lane 0 ALU blocked while other units and lane 1 keep flowing
        rows[4]  = '{1'b0, EX_ALU, 4'b1000, 2'd3, 8'hFE, 8'd20};
        rows[5]  = '{1'b0, EX_ALU, 4'b0010, 2'd1, 8'hFE, 8'd20};
        rows[6]  = '{1'b1, EX_LSU, 4'b0110, 2'd2, 8'hFE, 8'd20};
        rows[7]  = '{1'b0, EX_LSU, 4'b1010, 2'd3, 8'hFE, 8'd20};
        rows[8]  = '{1'b0, EX_ALU, 4'b1100, 2'd3, 8'hFE, 8'd6};
        // Lane 1 FPU fills up
        rows[9]  = '{1'b1, EX_FPU, 4'b0011, 2'd1, 8'hBF, 8'd15};
        rows[10] = '{1'b1, EX_FPU, 4'b0100, 2'd2, 8'hBF, 8'd15};
        rows[11] = '{1'b1, EX_FPU, 4'b1001, 2'd3, 8'hBF, 8'd4};
        // Lane 1 SFU fills up
        rows[12] = '{1'b0, EX_SFU, 4'b0111, 2'd2, 8'h7F, 8'd10};
        rows[13] = '{1'b1, EX_SFU, 4'b0001, 2'd0, 8'h7F, 8'd10};
        rows[14] = '{1'b1, EX_SFU, 4'b1110, 2'd3, 8'h7F, 8'd10};
        rows[15] = '{1'b1, EX_SFU, 4'b0000, 2'd0, 8'h7F, 8'd3};
        rows[16] = '{1'b0, EX_LSU, 4'b1111, 2'd3, 8'hFD, 8'd2};
        rows[17] = '{1'b0, EX_LSU, 4'b0100, 2'd2, 8'hFD, 8'd2};
        rows[18] = '{1'b0, EX_LSU, 4'b1011, 2'd3, 8'hFD, 8'd2};
        rows[19] = '{1'b1, EX_ALU, 4'b0010, 2'd1, 8'hFF, 8'd0};
    endtask

    // Random payload with one LFSR step per bit
    task automatic make_packet(input ex_unit_e ex, input logic [3:0] tmask,
                               output operands_t pkt);
        logic [$bits(operands_t)-1:0] bits;
        for (int b = 0; b < $bits(operands_t); b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits[b] = lfsr_state[0];
        end
        pkt         = bits;
        pkt.tmask   = tmask;
        pkt.ex_type = ex;
    endtask

    // Starts and ends 1 ns after a rising edge
    task automatic apply_row(input stim_row_t r);
        operands_t pkt;
        int        waited;
        logic      accepted;
        make_packet(r.ex_type, r.tmask, pkt);
        unit_ready        = r.ready_pat;
        op_data[r.lane]   = pkt;
        row_tid[r.lane]   = r.exp_tid;
        op_valid[r.lane]  = 1'b1;
        waited   = 0;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = op_ready[r.lane];
            @(posedge clk);
            #1;
            waited++;
            if (!accepted && waited >= r.hold) begin
                unit_ready = '1;
            end
        end
        op_valid[r.lane] = 1'b0;
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        op_valid   = '0;
        op_data    = '0;
        row_tid    = '0;
        unit_ready = '1;
        lfsr_state = 32'h87716367;
        load_table();
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        @(posedge clk);
        #1;
        for (int n = 0; n < NUM_ROWS; n++) begin
            apply_row(rows[n]);
        end
        // Drain everything still buffered
        unit_ready = '1;
        while (pending != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("Checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- sim/dispatch_checker.sv
`timescale 1ns/1ps

module dispatch_checker import dispatch_pkg::*; #(
    parameter int ISSUE_WIDTH   = 2,
    parameter int PERF_CTR_BITS = 16
) (
    input  logic                                       clk,
    input  logic                                       reset,

    input  logic      [ISSUE_WIDTH-1:0]                op_valid,
    input  operands_t [ISSUE_WIDTH-1:0]                op_data,
    input  logic      [ISSUE_WIDTH-1:0]                op_ready,
    input  logic      [ISSUE_WIDTH-1:0][NT_BITS-1:0]   exp_tid,

    input  logic      [ISSUE_WIDTH-1:0][NUM_UNITS-1:0] unit_valid,
    input  dispatch_t [ISSUE_WIDTH-1:0][NUM_UNITS-1:0] unit_data,
    input  logic      [ISSUE_WIDTH-1:0][NUM_UNITS-1:0] unit_ready,
    input  logic [NUM_UNITS-1:0][PERF_CTR_BITS-1:0]    stall_count,

    output int                                         error_count,
    output int                                         check_count,
    output int                                         pending
);

    // Key is lane * NUM_UNITS + unit
    typedef struct packed {
        logic [7:0] key;
        dispatch_t  pkt;
    } expect_t;

    expect_t                  expect_q[$];
    logic [PERF_CTR_BITS-1:0] model_count [NUM_UNITS];
    int                       errors = 0;
    int                       checks = 0;
    int                       pending_n = 0;
    logic                     in_reset = 1'b0;

    assign error_count = errors;
    assign check_count = checks;
    assign pending     = pending_n;

    // Packet as the unit should see it with tid from the stimulus table
    function automatic dispatch_t expected_packet(input operands_t op,
                                                  input logic [NT_BITS-1:0] tid);
        dispatch_t d;
        d.uuid     = op.uuid;
        d.wid      = op.wid;
        d.tmask    = op.tmask;
        d.op_type  = op.op_type;
        d.op_mod   = op.op_mod;
        d.use_pc   = op.use_pc;
        d.use_imm  = op.use_imm;
        d.wb       = op.wb;
        d.pc       = op.pc;
        d.imm      = op.imm;
        d.rd       = op.rd;
        d.rs1_data = op.rs1_data;
        d.rs2_data = op.rs2_data;
        d.rs3_data = op.rs3_data;
        d.tid      = tid;
        return d;
    endfunction

    // Items still held in the buffer of one lane and unit
    function automatic int held_count(input int key);
        int n;
        n = 0;
        foreach (expect_q[k]) begin
            if (expect_q[k].key == key) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic check_reset_state();
        checks++;
        if (unit_valid !== '0 || op_ready !== '1) begin
            errors++;
            $display("CHECK FAILED at %0t: after reset unit_valid=%h op_ready=%b",
                     $time, unit_valid, op_ready);
        end
    endtask

    task automatic check_counts();
        for (int u = 0; u < NUM_UNITS; u++) begin
            checks++;
            if (stall_count[u] !== model_count[u]) begin
                errors++;
                $display("CHECK FAILED at %0t: stall_count[%0d] is %0d, expected %0d",
                         $time, u, stall_count[u], model_count[u]);
            end
        end
    endtask

    // Lane input waits only while its target buffer holds two items
    task automatic check_ready(input int lane);
        logic want;
        want = held_count(lane * NUM_UNITS + int'(op_data[lane].ex_type)) < 2;
        checks++;
        if (op_ready[lane] !== want) begin
            errors++;
            $display("CHECK FAILED at %0t: lane %0d op_ready is %b, expected %b",
                     $time, lane, op_ready[lane], want);
        end
    endtask

    // Oldest pending packet for this lane and unit must match
    task automatic match_output(input int lane, input int unit);
        int      idx;
        expect_t e;
        idx = -1;
        for (int k = 0; k < expect_q.size(); k++) begin
            if (idx < 0 && expect_q[k].key == lane * NUM_UNITS + unit) begin
                idx = k;
            end
        end
        if (idx < 0) begin
            errors++;
            $display("Lane %0d unit %0d sent a packet that was never accepted for it, at %0t",
                     lane, unit, $time);
        end else begin
            checks++;
            e = expect_q[idx];
            if (unit_data[lane][unit] !== e.pkt) begin
                errors++;
                $display("CHECK FAILED at %0t: lane %0d unit %0d got uuid %h tid %0d, %s %h %0d",
                         $time, lane, unit, unit_data[lane][unit].uuid,
                         unit_data[lane][unit].tid, "expected uuid/tid", e.pkt.uuid, e.pkt.tid);
            end
            expect_q.delete(idx);
        end
    endtask

    // Sample mid-cycle when every input and output is settled
    always @(negedge clk) begin
        expect_t e;
        if (reset) begin
            in_reset = 1'b1;
            for (int u = 0; u < NUM_UNITS; u++) begin
                model_count[u] = '0;
            end
        end else begin
            if (in_reset) begin
                check_reset_state();
                in_reset = 1'b0;
            end
            check_counts();
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                if (op_valid[i]) begin
                    check_ready(i);
                end
            end
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                if (op_valid[i] && !op_ready[i]) begin
                    model_count[op_data[i].ex_type] = model_count[op_data[i].ex_type] + 1'b1;
                end
                if (op_valid[i] && op_ready[i]) begin
                    e.key = 8'(i * NUM_UNITS + int'(op_data[i].ex_type));
                    e.pkt = expected_packet(op_data[i], exp_tid[i]);
                    expect_q.push_back(e);
                end
            end
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                for (int u = 0; u < NUM_UNITS; u++) begin
                    if (unit_valid[i][u] && unit_ready[i][u]) begin
                        match_output(i, u);
                    end
                end
            end
            pending_n = expect_q.size();
        end
    end

endmodule

//--- verilog/dispatch_top.sv
`timescale 1ns/1ps

module dispatch_top import dispatch_pkg::*; #(
    parameter int ISSUE_WIDTH   = 2,
    parameter int PERF_CTR_BITS = 16
) (
    input  logic                                         clk,
    input  logic                                         reset,

    // Operand packets, one per issue lane
    input  logic      [ISSUE_WIDTH-1:0]                  op_valid,
    input  operands_t [ISSUE_WIDTH-1:0]                  op_data,
    output logic      [ISSUE_WIDTH-1:0]                  op_ready,

    // Dispatch ports, per lane and unit
    output logic      [ISSUE_WIDTH-1:0][NUM_UNITS-1:0]   unit_valid,
    output dispatch_t [ISSUE_WIDTH-1:0][NUM_UNITS-1:0]   unit_data,
    input  logic      [ISSUE_WIDTH-1:0][NUM_UNITS-1:0]   unit_ready,

    // Stall cycles per unit type
    output logic [NUM_UNITS-1:0][PERF_CTR_BITS-1:0]      stall_count
);

    ex_unit_e [ISSUE_WIDTH-1:0] lane_unit;

    for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : g_lane
        assign lane_unit[i] = op_data[i].ex_type;

        dispatch_lane lane_i (
            .clk        (clk),
            .reset      (reset),
            .op_valid   (op_valid[i]),
            .op_data    (op_data[i]),
            .op_ready   (op_ready[i]),
            .unit_valid (unit_valid[i]),
            .unit_data  (unit_data[i]),
            .unit_ready (unit_ready[i])
        );
    end

    // Stalls seen at the lane inputs
    stall_counters #(
        .ISSUE_WIDTH   (ISSUE_WIDTH),
        .PERF_CTR_BITS (PERF_CTR_BITS)
    ) stall_counters_i (
        .clk         (clk),
        .reset       (reset),
        .op_valid    (op_valid),
        .op_ready    (op_ready),
        .op_unit     (lane_unit),
        .stall_count (stall_count)
    );

endmodule

//--- verilog/stall_counters.sv
`timescale 1ns/1ps

module stall_counters import dispatch_pkg::*; #(
    parameter int ISSUE_WIDTH   = 2,
    parameter int PERF_CTR_BITS = 16
) (
    input  logic                                    clk,
    input  logic                                    reset,

    input  logic     [ISSUE_WIDTH-1:0]              op_valid,
    input  logic     [ISSUE_WIDTH-1:0]              op_ready,
    input  ex_unit_e [ISSUE_WIDTH-1:0]              op_unit,

    output logic     [NUM_UNITS-1:0][PERF_CTR_BITS-1:0] stall_count
);

    logic [ISSUE_WIDTH-1:0]                    lane_stall;
    logic [NUM_UNITS-1:0][PERF_CTR_BITS-1:0]   stall_sum;
    logic [NUM_UNITS-1:0][PERF_CTR_BITS-1:0]   count_r;

    assign lane_stall = op_valid & ~op_ready;

    // Stalled lanes per unit type this cycle
    always_comb begin
        stall_sum = '0;
        for (int u = 0; u < NUM_UNITS; u++) begin
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                if (lane_stall[i] && (op_unit[i] == ex_unit_e'(u))) begin
                    stall_sum[u] = stall_sum[u] + PERF_CTR_BITS'(1);
                end
            end
        end
    end

    // Wraps naturally at the counter width
    always_ff @(posedge clk) begin
        if (reset) begin
            count_r <= '0;
        end else begin
            for (int u = 0; u < NUM_UNITS; u++) begin
                count_r[u] <= count_r[u] + stall_sum[u];
            end
        end
    end

    assign stall_count = count_r;

endmodule

//--- verilog/dispatch_lane.sv
`timescale 1ns/1ps

module dispatch_lane import dispatch_pkg::*; (
    input  logic                           clk,
    input  logic                           reset,

    // From operand collection
    input  logic                           op_valid,
    input  operands_t                      op_data,
    output logic                           op_ready,

    // Toward the execution units
    output logic      [NUM_UNITS-1:0]      unit_valid,
    output dispatch_t [NUM_UNITS-1:0]      unit_data,
    input  logic      [NUM_UNITS-1:0]      unit_ready
);

    logic [NT_BITS-1:0]   last_tid;
    dispatch_t            disp_data;
    logic [NUM_UNITS-1:0] buf_valid;
    logic [NUM_UNITS-1:0] buf_ready;

    last_thread_find tid_find_i (
        .tmask (op_data.tmask),
        .tid   (last_tid)
    );

    // Repack the operand packet with the last active thread
    always_comb begin
        disp_data.uuid     = op_data.uuid;
        disp_data.wid      = op_data.wid;
        disp_data.tmask    = op_data.tmask;
        disp_data.op_type  = op_data.op_type;
        disp_data.op_mod   = op_data.op_mod;
        disp_data.use_pc   = op_data.use_pc;
        disp_data.use_imm  = op_data.use_imm;
        disp_data.wb       = op_data.wb;
        disp_data.pc       = op_data.pc;
        disp_data.imm      = op_data.imm;
        disp_data.rd       = op_data.rd;
        disp_data.rs1_data = op_data.rs1_data;
        disp_data.rs2_data = op_data.rs2_data;
        disp_data.rs3_data = op_data.rs3_data;
        disp_data.tid      = last_tid;
    end

    // One buffer per unit type
    for (genvar u = 0; u < NUM_UNITS; u++) begin : g_unit
        // Only the buffer matching ex_type sees the valid
        assign buf_valid[u] = op_valid && (op_data.ex_type == ex_unit_e'(u));

        elastic_buffer unit_buf_i (
            .clk       (clk),
            .reset     (reset),
            .valid_in  (buf_valid[u]),
            .ready_in  (buf_ready[u]),
            .data_in   (disp_data),
            .valid_out (unit_valid[u]),
            .data_out  (unit_data[u]),
            .ready_out (unit_ready[u])
        );
    end

    // Lane stalls only on its own target buffer
    assign op_ready = buf_ready[op_data.ex_type];

endmodule

//--- verilog/elastic_buffer.sv
`timescale 1ns/1ps

module elastic_buffer import dispatch_pkg::*; (
    input  logic      clk,
    input  logic      reset,

    input  logic      valid_in,
    output logic      ready_in,
    input  dispatch_t data_in,

    output logic      valid_out,
    output dispatch_t data_out,
    input  logic      ready_out
);

    logic      out_valid;
    dispatch_t out_data;
    logic      skid_valid;
    dispatch_t skid_data;

    logic      push;
    logic      pop;
    logic      out_free;

    assign push     = valid_in && ready_in;
    assign pop      = out_valid && ready_out;

    // Output slot can take a new item this edge
    assign out_free = !out_valid || pop;

    // Control state
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            if (out_free) begin
                // Skid entry is older, so it goes first
                if (skid_valid) begin
                    out_valid  <= 1'b1;
                    skid_valid <= 1'b0;
                end else begin
                    out_valid  <= push;
                end
            end else if (push) begin
                skid_valid <= 1'b1;
            end
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (out_free) begin
            if (skid_valid) begin
                out_data <= skid_data;
            end else if (push) begin
                out_data <= data_in;
            end
        end else if (push) begin
            skid_data <= data_in;
        end
    end

    // Registered ready drops only while both entries hold items
    assign ready_in  = !skid_valid;

    assign valid_out = out_valid;
    assign data_out  = out_data;

endmodule

//--- verilog/last_thread_find.sv
`timescale 1ns/1ps

module last_thread_find import dispatch_pkg::*; (
    input  logic [NUM_THREADS-1:0] tmask,
    output logic [NT_BITS-1:0]     tid
);

    logic [NT_BITS-1:0] tid_sel;

    // Scan upward so the highest set bit is the one kept
    always_comb begin
        tid_sel = '0;
        for (int i = 0; i < NUM_THREADS; i++) begin
            if (tmask[i]) begin
                tid_sel = NT_BITS'(i);
            end
        end
    end

    // Empty mask falls through as thread 0
    assign tid = tid_sel;

endmodule

//--- verilog/dispatch_pkg.sv
package dispatch_pkg;

    // Core geometry
    localparam int NUM_THREADS = 4;
    localparam int XLEN        = 32;
    localparam int NW_BITS     = 2;
    localparam int NT_BITS     = 2;
    localparam int NR_BITS     = 5;

    // Instruction fields
    localparam int UUID_BITS   = 16;
    localparam int OP_BITS     = 4;
    localparam int MOD_BITS    = 3;

    localparam int NUM_UNITS   = 4;

    // Also used as index into the per-unit arrays
    typedef enum logic [1:0] {
        EX_ALU = 2'd0,
        EX_LSU = 2'd1,
        EX_FPU = 2'd2,
        EX_SFU = 2'd3
    } ex_unit_e;

    // Packet from operand collection
    typedef struct packed {
        logic [UUID_BITS-1:0]              uuid;
        logic [NW_BITS-1:0]                wid;
        logic [NUM_THREADS-1:0]            tmask;
        logic [OP_BITS-1:0]                op_type;
        logic [MOD_BITS-1:0]               op_mod;
        logic                              use_pc;
        logic                              use_imm;
        logic                              wb;
        logic [XLEN-1:0]                   pc;
        logic [XLEN-1:0]                   imm;
        logic [NR_BITS-1:0]                rd;
        logic [NUM_THREADS-1:0][XLEN-1:0]  rs1_data;
        logic [NUM_THREADS-1:0][XLEN-1:0]  rs2_data;
        logic [NUM_THREADS-1:0][XLEN-1:0]  rs3_data;
        ex_unit_e                          ex_type;
    } operands_t;

    // Packet as an execution unit sees it
    typedef struct packed {
        logic [UUID_BITS-1:0]              uuid;
        logic [NW_BITS-1:0]                wid;
        logic [NUM_THREADS-1:0]            tmask;
        logic [OP_BITS-1:0]                op_type;
        logic [MOD_BITS-1:0]               op_mod;
        logic                              use_pc;
        logic                              use_imm;
        logic                              wb;
        logic [XLEN-1:0]                   pc;
        logic [XLEN-1:0]                   imm;
        logic [NR_BITS-1:0]                rd;
        logic [NUM_THREADS-1:0][XLEN-1:0]  rs1_data;
        logic [NUM_THREADS-1:0][XLEN-1:0]  rs2_data;
        logic [NUM_THREADS-1:0][XLEN-1:0]  rs3_data;
        logic [NT_BITS-1:0]                tid;
    } dispatch_t;

endpackage
